// ==== verilog/front_params.svh ====
`ifndef FRONT_PARAMS_SVH
`define FRONT_PARAMS_SVH

// first address fetched once reset is released
`define FRONT_RESET_PC 32'h1c00_0000

`define FRONT_INST_W 32

// major opcode of the unconditional branch B
`define FRONT_OP_B 6'b010100

// icache_op encoding, zero means the bus is idle
`define FRONT_ICACHE_OP_FETCH 3'b001

`endif

// ==== verilog/front_pkg.sv ====
`default_nettype none
`include "front_params.svh"

package front_pkg;

    typedef logic [31:0] u32_t;

    //##################################################
    // stage pass registers
    //##################################################

    typedef struct packed {
        logic valid;
        u32_t pc;
    } fetch1_fetch2_pass_t;

    typedef struct packed {
        logic                     valid;
        u32_t                     pc;
        logic [`FRONT_INST_W-1:0] inst;
    } fetch2_decode_pass_t;

    // what leaves decode toward the issue stage
    typedef struct packed {
        logic                     valid;
        u32_t                     pc;
        logic [`FRONT_INST_W-1:0] inst;
    } issue_pass_t;

    //##################################################
    // redirect from decode back to fetch1
    //##################################################

    typedef struct packed {
        logic valid;
        u32_t target;
    } wr_pc_req_t;

endpackage

`default_nettype wire

// ==== verilog/fetch1.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "front_params.svh"

module fetch1 import front_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                is_stall,
    input  logic                is_flush,
    input  wr_pc_req_t          wr_pc_req,
    output logic [2:0]          icache_op,
    output u32_t                icache_pa,
    output logic [11:0]         icache_idx,
    output fetch1_fetch2_pass_t pass_out
);

    u32_t pc;
    logic fetch_en;
    logic fire;

    // the cache takes the address only while the fetch code is on the bus
    assign fire = fetch_en && !is_stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
        end
    end

    // a redirect wins over a stall, the younger fetches are flushed anyway
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `FRONT_RESET_PC;
        end else if (wr_pc_req.valid) begin
            pc <= wr_pc_req.target;
        end else if (fire) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_out <= '0;
        end else if (is_flush) begin
            pass_out.valid <= 1'b0;
        end else if (!is_stall) begin
            pass_out.valid <= fetch_en;
            pass_out.pc    <= pc;
        end
    end

    assign icache_op  = fetch_en ? `FRONT_ICACHE_OP_FETCH : 3'b000;
    assign icache_pa  = pc;
    assign icache_idx = pc[11:0];

endmodule

`default_nettype wire

// ==== verilog/fetch2.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "front_params.svh"

module fetch2 import front_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                is_stall,
    input  logic                is_flush,
    input  fetch1_fetch2_pass_t pass_in,
    input  logic                icache_ready,
    input  u32_t                icache_data,
    output logic                icache_stall,
    output fetch2_decode_pass_t pass_out
);

    logic                     resp_held;
    logic [`FRONT_INST_W-1:0] resp_data;
    logic                     resp_ok;
    logic [`FRONT_INST_W-1:0] inst;
    fetch2_decode_pass_t      out_q;

    assign resp_ok      = resp_held || icache_ready;
    assign inst         = resp_held ? resp_data : icache_data;
    assign icache_stall = pass_in.valid && !resp_ok;

    //##################################################
    // response buffer
    //##################################################

    // ready may be a single pulse, so an answer that arrives while
    // decode holds the pipe is kept here until the entry moves on
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_held <= 1'b0;
        end else if (is_flush || !is_stall) begin
            resp_held <= 1'b0;
        end else if (pass_in.valid && icache_ready) begin
            resp_held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (pass_in.valid && icache_ready && !resp_held) begin
            resp_data <= icache_data;
        end
    end

    //##################################################
    // output register
    //##################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q <= '0;
        end else if (is_flush) begin
            out_q.valid <= 1'b0;
        end else if (!is_stall) begin
            // not stalled means a valid entry already has its data
            out_q.valid <= pass_in.valid;
            out_q.pc    <= pass_in.pc;
            out_q.inst  <= inst;
        end
    end

    // decode keeps running while fetch2 waits on the cache, so the held
    // entry is shown only in cycles where it can move on
    always_comb begin
        pass_out       = out_q;
        pass_out.valid = out_q.valid && !icache_stall;
    end

endmodule

`default_nettype wire

// ==== verilog/decode.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "front_params.svh"

module decode import front_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                is_stall,
    input  fetch2_decode_pass_t pass_in,
    input  logic                issue_ready,
    output wr_pc_req_t          wr_pc_req,
    output logic                issue_stall,
    output issue_pass_t         issue
);

    logic [5:0]  opcode;
    logic [25:0] offs;
    logic        is_b;
    u32_t        target;

    //##################################################
    // branch recognition
    //##################################################

    assign opcode = pass_in.inst[31:26];

    // offs[15:0] sits in bits 25:10 and offs[25:16] in bits 9:0
    assign offs = {pass_in.inst[9:0], pass_in.inst[25:10]};

    assign is_b   = pass_in.valid && (opcode == `FRONT_OP_B);
    assign target = pass_in.pc + {{4{offs[25]}}, offs, 2'b00};

    // the B is consumed by the fetch2 flush, so it fires only once
    // even while the issue port is held
    assign wr_pc_req.valid  = is_b;
    assign wr_pc_req.target = target;

    //##################################################
    // issue port
    //##################################################

    assign issue_stall = issue.valid && !issue_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issue <= '0;
        end else if (!is_stall) begin
            issue.valid <= pass_in.valid && !is_b;
            issue.pc    <= pass_in.pc;
            issue.inst  <= pass_in.inst;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/front_end_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module front_end_top import front_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    output logic [2:0]  icache_op,
    output u32_t        icache_pa,
    output logic [11:0] icache_idx,
    output logic        is_icache_stall,
    input  logic        icache_ready,
    input  u32_t        icache_data,
    output issue_pass_t issue,
    input  logic        issue_ready
);

    fetch1_fetch2_pass_t pass_if1;
    fetch2_decode_pass_t pass_if2;
    wr_pc_req_t          id_wr_pc_req;

    logic icache_stall;
    logic issue_stall;

    logic stall_if1;
    logic stall_if2;
    logic stall_id;
    logic flush_if1;
    logic flush_if2;

    fetch1 fetch1_i (
        .clk,
        .rst_n,
        .is_stall   (stall_if1),
        .is_flush   (flush_if1),
        .wr_pc_req  (id_wr_pc_req),
        .icache_op,
        .icache_pa,
        .icache_idx,
        .pass_out   (pass_if1)
    );

    fetch2 fetch2_i (
        .clk,
        .rst_n,
        .is_stall     (stall_if2),
        .is_flush     (flush_if2),
        .pass_in      (pass_if1),
        .icache_ready,
        .icache_data,
        .icache_stall,
        .pass_out     (pass_if2)
    );

    decode decode_i (
        .clk,
        .rst_n,
        .is_stall    (stall_id),
        .pass_in     (pass_if2),
        .issue_ready,
        .wr_pc_req   (id_wr_pc_req),
        .issue_stall,
        .issue
    );

    //##################################################
    // per-stage stall and flush
    //##################################################

    // an older stage holding also holds every younger one
    assign stall_if1 = icache_stall | issue_stall;
    assign stall_if2 = icache_stall | issue_stall;
    assign stall_id  = issue_stall;

    assign flush_if1 = id_wr_pc_req.valid;
    assign flush_if2 = id_wr_pc_req.valid;

    assign is_icache_stall = stall_if1;

endmodule

`default_nettype wire

// ==== bench/front_end_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "front_params.svh"

module front_end_tb import front_pkg::*; ();

    localparam int          TRACE_WORDS   = 64;
    localparam int          START_TIMEOUT = 20;
    localparam int          XFER_TIMEOUT  = 200;
    localparam int          TAIL_CYCLES   = 50;
    localparam logic [31:0] NOP_INST      = 32'h0340_0000;

    logic        clk;
    logic        rst_n;
    logic [2:0]  icache_op;
    u32_t        icache_pa;
    logic [11:0] icache_idx;
    logic        is_icache_stall;
    logic        icache_ready;
    u32_t        icache_data;
    issue_pass_t issue;
    logic        issue_ready;

    u32_t trace [0:TRACE_WORDS-1];
    int   mem_count;
    int   exp_count;

    u32_t        lfsr;
    u32_t        latched_pa;
    u32_t        pending_pa;
    logic        accept_pending;
    logic        xfer;
    logic        held;
    issue_pass_t held_item;

    front_end_top dut_i (
        .clk,
        .rst_n,
        .icache_op,
        .icache_pa,
        .icache_idx,
        .is_icache_stall,
        .icache_ready,
        .icache_data,
        .issue,
        .issue_ready
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    //##################################################
    // helpers
    //##################################################

    function automatic u32_t lfsr_next(input u32_t s);
        u32_t n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // words not listed in the trace read as NOP
    function automatic u32_t mem_word(input u32_t addr);
        u32_t w;
        int   i;
        w = NOP_INST;
        for (i = 0; i < mem_count; i++) begin
            if (trace[2 + 2 * i] == addr) begin
                w = trace[3 + 2 * i];
            end
        end
        return w;
    endfunction

    task automatic check(input string name, input u32_t expected, input u32_t actual);
        if (expected !== actual) begin
            $display("ERR %s expected %h actual %h", name, expected, actual);
            $display("tests failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        $display("tests failed");
        $fatal(1, "stopped on a timeout");
    endtask

    //##################################################
    // icache model and issue sink, one cycle per call
    //##################################################

    // drives at the falling edge, then samples what the next rising edge sees
    task automatic run_cycle();
        @(negedge clk);
        // the edge that just passed took the address sampled last cycle
        if (accept_pending) begin
            latched_pa = pending_pa;
        end
        lfsr = lfsr_next(lfsr);
        icache_ready = lfsr[0];
        icache_data = mem_word(latched_pa);
        lfsr = lfsr_next(lfsr);
        issue_ready = lfsr[0];
        #1;
        accept_pending = (icache_op == `FRONT_ICACHE_OP_FETCH) && !is_icache_stall;
        pending_pa = icache_pa;
        if (issue.valid && !issue_ready) begin
            check("fetch stall under back-pressure", 32'd1, {31'd0, is_icache_stall});
        end
        if (held) begin
            check("issue valid held", 32'd1, {31'd0, issue.valid});
            check("issue pc held", held_item.pc, issue.pc);
            check("issue inst held", held_item.inst, issue.inst);
        end
        held = issue.valid && !issue_ready;
        held_item = issue;
        xfer = issue.valid && issue_ready;
    endtask

    //##################################################
    // main sequence
    //##################################################

    initial begin
        int   waited;
        int   n;
        int   c;
        u32_t exp_pc;
        u32_t exp_inst;

        rst_n = 1'b0;
        icache_ready = 1'b0;
        icache_data = NOP_INST;
        issue_ready = 1'b0;
        lfsr = 32'h494d_ae34;
        latched_pa = `FRONT_RESET_PC;
        pending_pa = `FRONT_RESET_PC;
        accept_pending = 1'b0;
        held = 1'b0;
        held_item = '0;
        xfer = 1'b0;

        $readmemh("bench/fetch_trace.txt", trace);
        mem_count = int'(trace[0]);
        exp_count = int'(trace[1]);

        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // the fetch request comes up right after reset release
        waited = 0;
        while (icache_op != `FRONT_ICACHE_OP_FETCH) begin
            if (waited == START_TIMEOUT) begin
                report_timeout("icache_op never showed a fetch request after reset");
            end
            run_cycle();
            waited++;
        end
        check("icache pa", `FRONT_RESET_PC, icache_pa);
        check("icache idx", `FRONT_RESET_PC & 32'h0000_0fff, {20'd0, icache_idx});

        for (n = 0; n < exp_count; n++) begin
            waited = 0;
            do begin
                if (waited == XFER_TIMEOUT) begin
                    report_timeout("no issue transfer arrived for the next expected item");
                end
                run_cycle();
                waited++;
            end while (!xfer);

            exp_pc = trace[2 + 2 * mem_count + 2 * n];
            exp_inst = trace[3 + 2 * mem_count + 2 * n];
            if (n == 0) begin
                check("first pc is reset pc", `FRONT_RESET_PC, issue.pc);
            end
            check($sformatf("issue %0d pc", n), exp_pc, issue.pc);
            check($sformatf("issue %0d inst", n), exp_inst, issue.inst);
            check($sformatf("issue %0d memory word", n), mem_word(exp_pc), issue.inst);
        end

        // the stream ends in a B to itself, so nothing more may come out
        for (c = 0; c < TAIL_CYCLES; c++) begin
            run_cycle();
            check("no issue after end of stream", 32'd0, {31'd0, issue.valid});
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/front_pkg.sv
verilog/fetch1.sv
verilog/fetch2.sv
verilog/decode.sv
verilog/front_end_top.sv
bench/front_end_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the front end testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/100ps -f build.f --top-module front_end_tb \
    -Mdir obj_dir -o front_end_tb_sim \
    && ./obj_dir/front_end_tb_sim \
    || exit 1

// ==== bench/fetch_trace.txt ====
// word 0: number of memory pairs, word 1: number of expected issue pairs
// memory pairs are (address instruction), expected issue pairs are (pc instruction)
0000000d
00000008
// memory image, unlisted words read as NOP
1c000000 02800401
1c000004 02800802
1c000008 02800c03
1c00000c 50003400
1c000010 02801004
1c000014 02801405
1c000040 02802006
1c000044 02802407
1c000048 53ffdbff
1c00004c 02802808
1c000020 02803009
1c000028 0280340a
1c00002c 50000000
// expected issue stream
1c000000 02800401
1c000004 02800802
1c000008 02800c03
1c000040 02802006
1c000044 02802407
1c000020 02803009
1c000024 03400000
1c000028 0280340a
